// ==== flist.f ====
source/isaPkg.sv
source/pipePkg.sv
source/pipeReg.sv
source/instrDecoder.sv
source/regFile.sv
source/idexReg.sv
source/executeUnit.sv
source/pipeControl.sv
source/retireCounter.sv
source/decodeExecuteTop.sv
tb/decodeExecuteTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode-to-writeback testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module decodeExecuteTb \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1

// ==== tb/decodeExecuteTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeExecuteTb import isaPkg::*; ();

    localparam int    CountWidth  = 16;
    localparam word_t ResetPc     = 16'h0100;
    localparam int    MaxEntries  = 32;
    localparam int    HaltTimeout = 20;

    logic                  clk;
    logic                  rst;
    word_t                 instr;
    word_t                 pc;
    logic                  wbRegWrite;
    regIdx_t               wbReg;
    word_t                 wbData;
    logic                  redirect;
    word_t                 redirectPc;
    logic                  halted;
    logic [CountWidth-1:0] retiredCount;
    logic [CountWidth-1:0] squashedCount;

    // Stimulus fields, then the expected results filled in by the model.
    opcode_t     tOp [MaxEntries];
    logic [2:0]  tRd [MaxEntries];
    logic [2:0]  tRs [MaxEntries];
    logic [2:0]  tRt [MaxEntries];
    logic [1:0]  tFn [MaxEntries];
    logic [10:0] tImm [MaxEntries];
    logic        expWrite [MaxEntries];
    logic        expRedirect [MaxEntries];
    word_t       expData [MaxEntries];
    word_t       expTarget [MaxEntries];
    logic        entryBad [MaxEntries];
    int          numEntries;
    int          errorCount;
    int          failedTests;
    int          expRetired;
    int          expSquashed;
    integer      seed;

    decodeExecuteTop #(.CountWidth(CountWidth), .ResetPc(ResetPc)) DUT (
        .clk, .rst, .instr, .pc, .wbRegWrite, .wbReg, .wbData, .redirect, .redirectPc,
        .halted, .retiredCount, .squashedCount
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t sext(input logic [10:0] value, input int width);
        case (width)
            5:       return word_t'(signed'(value[4:0]));
            8:       return word_t'(signed'(value[7:0]));
            default: return word_t'(signed'(value));
        endcase
    endfunction

    function automatic word_t encode(input int k);
        case (tOp[k])
            OpRType:        return {tOp[k], tRs[k], tRt[k], tRd[k], tFn[k]};
            OpAddi, OpXori: return {tOp[k], tRs[k], tRd[k], tImm[k][4:0]};
            OpBeqz, OpBnez: return {tOp[k], tRs[k], tImm[k][7:0]};
            OpJ:            return {tOp[k], tImm[k]};
            default:        return {tOp[k], 11'd0};
        endcase
    endfunction

    task automatic addEntry(input opcode_t op, input int rd, input int rs, input int rt,
                            input int fn, input int imm);
        tOp[numEntries]  = op;
        tRd[numEntries]  = 3'(rd);
        tRs[numEntries]  = 3'(rs);
        tRt[numEntries]  = 3'(rt);
        tFn[numEntries]  = 2'(fn);
        tImm[numEntries] = 11'(imm);
        numEntries++;
    endtask

    // Program-order model; a taken branch kills the next entry, a halt kills the rest.
    task automatic buildExpected();
        word_t refRegs [8];
        word_t a;
        word_t b;
        word_t pcK;
        logic  squashNext;
        logic  haltedModel;
        logic  taken;
        for (int r = 0; r < 8; r++) begin
            refRegs[r] = '0;
        end
        squashNext  = 1'b0;
        haltedModel = 1'b0;
        expRetired  = 0;
        expSquashed = 0;
        for (int k = 0; k < numEntries; k++) begin
            a              = refRegs[tRs[k]];
            b              = refRegs[tRt[k]];
            pcK            = ResetPc + word_t'(2 * k);
            taken          = 1'b0;
            expWrite[k]    = 1'b0;
            expRedirect[k] = 1'b0;
            expData[k]     = '0;
            expTarget[k]   = '0;
            if (haltedModel || squashNext) begin
                squashNext = 1'b0;
            end else begin
                case (tOp[k])
                    OpRType: begin
                        expWrite[k] = 1'b1;
                        case (tFn[k])
                            2'd0:    expData[k] = a + b;
                            2'd1:    expData[k] = a - b;
                            2'd2:    expData[k] = a ^ b;
                            default: expData[k] = a & b;
                        endcase
                    end
                    OpAddi: begin
                        expWrite[k] = 1'b1;
                        expData[k]  = a + sext(tImm[k], 5);
                    end
                    OpXori: begin
                        expWrite[k] = 1'b1;
                        expData[k]  = a ^ sext(tImm[k], 5);
                    end
                    OpBeqz, OpBnez: begin
                        taken        = (tOp[k] == OpBeqz) ? (a == '0) : (a != '0);
                        expTarget[k] = pcK + 16'd2 + sext(tImm[k], 8);
                    end
                    OpJ: begin
                        taken        = 1'b1;
                        expTarget[k] = pcK + 16'd2 + sext(tImm[k], 11);
                    end
                    OpHalt: begin
                        // The halt cycle and the draining cycle each squash.
                        haltedModel = 1'b1;
                        expSquashed += 2;
                    end
                    default: begin
                    end
                endcase
                if (taken) begin
                    expRedirect[k] = 1'b1;
                    squashNext     = 1'b1;
                    expSquashed++;
                end
                if (expWrite[k]) begin
                    refRegs[tRd[k]] = expData[k];
                    expRetired++;
                end
            end
        end
    endtask

    task automatic checkValue(input int entry, input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errorCount++;
            if (entry >= 0) begin
                entryBad[entry] = 1'b1;
            end
        end
    endtask

    initial begin
        int   k;
        int   waitCycles;
        int   errorsBefore;
        logic timedOut;
        seed        = 32'h7eff_9a5d;
        errorCount  = 0;
        failedTests = 0;
        numEntries  = 0;
        rst         = 1'b1;
        instr       = '0;
        pc          = ResetPc;
        for (int i = 0; i < MaxEntries; i++) begin
            entryBad[i] = 1'b0;
        end

        addEntry(OpAddi, 1, 0, 0, 0, $random(seed));
        addEntry(OpAddi, 2, 1, 0, 0, $random(seed));
        addEntry(OpRType, 3, 1, 2, 0, 0);
        addEntry(OpRType, 4, 3, 2, 1, 0);
        addEntry(OpRType, 5, 4, 1, 2, 0);
        addEntry(OpRType, 6, 5, 3, 3, 0);
        addEntry(OpXori, 7, 6, 0, 0, $random(seed));
        addEntry(OpBeqz, 0, 0, 0, 0, 6);
        addEntry(OpAddi, 1, 1, 0, 0, 1);
        addEntry(OpBnez, 0, 0, 0, 0, 4);
        addEntry(OpAddi, 2, 0, 0, 0, -3);
        addEntry(OpBnez, 0, 2, 0, 0, -8);
        addEntry(OpAddi, 3, 0, 0, 0, 7);
        addEntry(OpJ, 0, 0, 0, 0, 100);
        addEntry(OpAddi, 4, 4, 0, 0, 1);
        addEntry(OpHalt, 0, 0, 0, 0, 0);
        buildExpected();

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // Entry k reaches EX one cycle after it is driven and writeback one cycle later.
        for (int c = 0; c <= numEntries + 1; c++) begin
            if (c >= 1 && c <= numEntries) begin
                k = c - 1;
                checkValue(k, $sformatf("entry %0d redirect", k), 32'(redirect),
                    32'(expRedirect[k]));
                // An idle redirect points back at the reset vector.
                checkValue(k, $sformatf("entry %0d redirectPc", k), 32'(redirectPc),
                    32'(expRedirect[k] ? expTarget[k] : ResetPc));
            end
            if (c >= 2) begin
                k = c - 2;
                checkValue(k, $sformatf("entry %0d wbRegWrite", k), 32'(wbRegWrite),
                    32'(expWrite[k]));
                if (expWrite[k]) begin
                    checkValue(k, $sformatf("entry %0d wbReg", k), 32'(wbReg), 32'(tRd[k]));
                    checkValue(k, $sformatf("entry %0d wbData", k), 32'(wbData),
                        32'(expData[k]));
                end
                $display("entry %0d %s: %s", k, tOp[k].name(), entryBad[k] ? "failed" : "ok");
                if (entryBad[k]) begin
                    failedTests++;
                end
            end
            // Past the table, keep issuing writes that the halt has to squash.
            instr = (c < numEntries) ? encode(c) : encode(0);
            pc    = ResetPc + word_t'(2 * c);
            @(posedge clk);
            #2;
        end

        errorsBefore = errorCount;
        waitCycles   = 0;
        while (!halted && waitCycles < HaltTimeout) begin
            checkValue(-1, "wbRegWrite while halting", 32'(wbRegWrite), 32'd0);
            instr = encode(0);
            @(posedge clk);
            #2;
            waitCycles++;
        end
        timedOut = !halted;
        if (timedOut) begin
            $display("Timeout: halted did not rise within %0d cycles", HaltTimeout);
        end else begin
            // Younger instructions keep arriving but must never write back.
            for (int c = 0; c < 4; c++) begin
                checkValue(-1, "wbRegWrite after halt", 32'(wbRegWrite), 32'd0);
                checkValue(-1, "halted level", 32'(halted), 32'd1);
                instr = encode(0);
                @(posedge clk);
                #2;
            end
        end
        $display("halt: %s", (timedOut || errorCount != errorsBefore) ? "failed" : "ok");
        if (timedOut || errorCount != errorsBefore) begin
            failedTests++;
        end

        errorsBefore = errorCount;
        checkValue(-1, "retiredCount", 32'(retiredCount), 32'(expRetired));
        checkValue(-1, "squashedCount", 32'(squashedCount), 32'(expSquashed));
        $display("counters: %s", (errorCount != errorsBefore) ? "failed" : "ok");
        if (errorCount != errorsBefore) begin
            failedTests++;
        end

        $display("%0d tests, %0d failed, %0d mismatches", numEntries + 2, failedTests,
            errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/decodeExecuteTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeExecuteTop import isaPkg::*; #(
    parameter int    CountWidth = pipePkg::CountWidth,
    parameter word_t ResetPc    = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  word_t                 instr,
    input  word_t                 pc,
    output logic                  wbRegWrite,
    output regIdx_t               wbReg,
    output word_t                 wbData,
    output logic                  redirect,
    output word_t                 redirectPc,
    output logic                  halted,
    output logic [CountWidth-1:0] retiredCount,
    output logic [CountWidth-1:0] squashedCount
);

    regIdx_t rs, rt, writeReg, exRs, exRt, exWriteReg;
    word_t   imm, jumpDist, read1, read2;
    word_t   exPc, exRead1, exRead2, exImm, exJumpDist;
    aluOp_t  aluOp, exAluOp;
    funct_t  funct, exFunct;
    logic    aluSrc, branch, branchNe, jump, regWrite, halt;
    logic    rsValid, rtValid, writeRegValid;
    logic    exAluSrc, exBranch, exBranchNe, exJump, exRegWrite, exHalt;
    logic    exRsValid, exRtValid, exWriteRegValid;
    logic    controlZeroIdEx, squashPulse, haltSeen, wbValid;

    instrDecoder decoder (
        .instr, .rs, .rt, .writeReg, .imm, .jumpDist, .aluOp, .funct, .aluSrc,
        .branch, .branchNe, .jump, .regWrite, .halt, .rsValid, .rtValid, .writeRegValid
    );

    regFile regs (
        .clk, .rst, .rs, .rt, .read1, .read2,
        .writeEn(wbRegWrite), .writeReg(wbReg), .writeData(wbData)
    );

    idexReg idex (
        .clk, .rst, .controlZeroIdEx,
        .pcIn(pc), .read1In(read1), .read2In(read2), .immIn(imm), .jumpDistIn(jumpDist),
        .functIn(funct), .writeRegIn(writeReg), .aluOpIn(aluOp), .aluSrcIn(aluSrc),
        .branchIn(branch), .branchNeIn(branchNe), .jumpIn(jump), .regWriteIn(regWrite),
        .haltIn(halt), .rsIn(rs), .rtIn(rt), .rsValidIn(rsValid), .rtValidIn(rtValid),
        .writeRegValidIn(writeRegValid),
        .pcOut(exPc), .read1Out(exRead1), .read2Out(exRead2), .immOut(exImm),
        .jumpDistOut(exJumpDist), .functOut(exFunct), .writeRegOut(exWriteReg),
        .aluOpOut(exAluOp), .aluSrcOut(exAluSrc), .branchOut(exBranch),
        .branchNeOut(exBranchNe), .jumpOut(exJump), .regWriteOut(exRegWrite),
        .haltOut(exHalt), .rsOut(exRs), .rtOut(exRt), .rsValidOut(exRsValid),
        .rtValidOut(exRtValid), .writeRegValidOut(exWriteRegValid)
    );

    executeUnit #(.ResetPc(ResetPc)) execute (
        .clk, .rst, .pc(exPc), .read1(exRead1), .read2(exRead2), .imm(exImm),
        .jumpDist(exJumpDist), .funct(exFunct), .writeReg(exWriteReg), .aluOp(exAluOp),
        .aluSrc(exAluSrc), .branch(exBranch), .branchNe(exBranchNe), .jump(exJump),
        .regWrite(exRegWrite), .halt(exHalt), .rs(exRs), .rt(exRt), .rsValid(exRsValid),
        .rtValid(exRtValid), .writeRegValid(exWriteRegValid),
        .redirect, .redirectPc, .haltSeen, .wbValid, .wbRegWrite, .wbReg, .wbData
    );

    pipeControl control (
        .clk, .rst, .redirect, .haltSeen, .wbValid, .controlZeroIdEx, .squashPulse, .halted
    );

    retireCounter #(.CountWidth(CountWidth)) counters (
        .clk, .rst, .wbRegWrite, .squashPulse, .retiredCount, .squashedCount
    );

endmodule

`default_nettype wire

// ==== source/retireCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module retireCounter #(
    parameter int CountWidth = pipePkg::CountWidth
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wbRegWrite,
    input  logic                  squashPulse,
    output logic [CountWidth-1:0] retiredCount,
    output logic [CountWidth-1:0] squashedCount
);

    // Both counters stop at all ones.
    always_ff @(posedge clk) begin
        if (rst) begin
            retiredCount  <= '0;
            squashedCount <= '0;
        end else begin
            if (wbRegWrite && !(&retiredCount)) begin
                retiredCount <= retiredCount + CountWidth'(1);
            end
            if (squashPulse && !(&squashedCount)) begin
                squashedCount <= squashedCount + CountWidth'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pipeControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeControl import pipePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic redirect,
    input  logic haltSeen,
    input  logic wbValid,
    output logic controlZeroIdEx,
    output logic squashPulse,
    output logic halted
);

    ctrlState_t state;
    ctrlState_t stateNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateRun;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            StateRun:      if (haltSeen) stateNext = StateDraining;
            StateDraining: stateNext = StateHalted;
            default:       stateNext = StateHalted;
        endcase
    end

    // A halt in EX also kills the younger instruction behind it.
    assign controlZeroIdEx = redirect || haltSeen || (state != StateRun);

    // Once halted the pipeline idles, so those cycles are not counted.
    assign squashPulse = controlZeroIdEx && (state != StateHalted);
    assign halted      = (state == StateHalted);

    haltedSticky: assert property (@(posedge clk) disable iff (rst)
        state == StateHalted |=> state == StateHalted);

    haltedQuiet: assert property (@(posedge clk) disable iff (rst)
        state == StateHalted |-> !wbValid);

endmodule

`default_nettype wire

// ==== source/executeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnit import isaPkg::*; #(
    parameter word_t ResetPc = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  word_t   pc,
    input  word_t   read1,
    input  word_t   read2,
    input  word_t   imm,
    input  word_t   jumpDist,
    input  funct_t  funct,
    input  regIdx_t writeReg,
    input  aluOp_t  aluOp,
    input  logic    aluSrc,
    input  logic    branch,
    input  logic    branchNe,
    input  logic    jump,
    input  logic    regWrite,
    input  logic    halt,
    input  regIdx_t rs,
    input  regIdx_t rt,
    input  logic    rsValid,
    input  logic    rtValid,
    input  logic    writeRegValid,
    output logic    redirect,
    output word_t   redirectPc,
    output logic    haltSeen,
    output logic    wbValid,
    output logic    wbRegWrite,
    output regIdx_t wbReg,
    output word_t   wbData
);

    word_t  rsData;
    word_t  rtData;
    word_t  operandB;
    word_t  aluResult;
    word_t  target;
    aluOp_t effOp;
    logic   live;

    // Forward from EX/WB; older values come through the register file bypass.
    assign rsData   = (rsValid && wbRegWrite && wbReg == rs) ? wbData : read1;
    assign rtData   = (rtValid && wbRegWrite && wbReg == rt) ? wbData : read2;
    assign operandB = aluSrc ? imm : rtData;

    always_comb begin
        effOp = aluOp;
        if (aluOp == AluFunct) begin
            case (funct)
                FunctAdd: effOp = AluAdd;
                FunctSub: effOp = AluSub;
                FunctXor: effOp = AluXor;
                default:  effOp = AluAnd;
            endcase
        end
        case (effOp)
            AluAdd:  aluResult = rsData + operandB;
            AluSub:  aluResult = rsData - operandB;
            AluXor:  aluResult = rsData ^ operandB;
            AluAnd:  aluResult = rsData & operandB;
            default: aluResult = operandB;
        endcase
    end

    assign target   = pc + PcStep + (jump ? jumpDist : imm);
    assign redirect = jump || (branch && (branchNe ? (rsData != '0) : (rsData == '0)));
    // Idle value points fetch back at the reset vector.
    assign redirectPc = redirect ? target : ResetPc;
    assign haltSeen   = halt;
    assign live       = regWrite || branch || jump || halt;

    pipeReg #(.T(logic)) wbValidFf (.clk, .rst, .clear(1'b0), .d(live), .q(wbValid));
    pipeReg #(.T(logic)) wbWriteFf (.clk, .rst, .clear(1'b0),
        .d(regWrite && writeRegValid), .q(wbRegWrite));
    pipeReg #(.T(regIdx_t)) wbRegFf (.clk, .rst, .clear(1'b0), .d(writeReg), .q(wbReg));
    pipeReg #(.T(word_t)) wbDataFf (.clk, .rst, .clear(1'b0), .d(aluResult), .q(wbData));

endmodule

`default_nettype wire

// ==== source/idexReg.sv ====
`timescale 1ns/100ps
`default_nettype none

module idexReg import isaPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    controlZeroIdEx,
    input  word_t   pcIn,
    input  word_t   read1In,
    input  word_t   read2In,
    input  word_t   immIn,
    input  word_t   jumpDistIn,
    input  funct_t  functIn,
    input  regIdx_t writeRegIn,
    input  aluOp_t  aluOpIn,
    input  logic    aluSrcIn,
    input  logic    branchIn,
    input  logic    branchNeIn,
    input  logic    jumpIn,
    input  logic    regWriteIn,
    input  logic    haltIn,
    input  regIdx_t rsIn,
    input  regIdx_t rtIn,
    input  logic    rsValidIn,
    input  logic    rtValidIn,
    input  logic    writeRegValidIn,
    output word_t   pcOut,
    output word_t   read1Out,
    output word_t   read2Out,
    output word_t   immOut,
    output word_t   jumpDistOut,
    output funct_t  functOut,
    output regIdx_t writeRegOut,
    output aluOp_t  aluOpOut,
    output logic    aluSrcOut,
    output logic    branchOut,
    output logic    branchNeOut,
    output logic    jumpOut,
    output logic    regWriteOut,
    output logic    haltOut,
    output regIdx_t rsOut,
    output regIdx_t rtOut,
    output logic    rsValidOut,
    output logic    rtValidOut,
    output logic    writeRegValidOut
);

    pipeReg #(.T(word_t)) pcFf (.clk, .rst, .clear(1'b0), .d(pcIn), .q(pcOut));
    pipeReg #(.T(word_t)) read1Ff (.clk, .rst, .clear(1'b0), .d(read1In), .q(read1Out));
    pipeReg #(.T(word_t)) read2Ff (.clk, .rst, .clear(1'b0), .d(read2In), .q(read2Out));
    pipeReg #(.T(word_t)) immFf (.clk, .rst, .clear(1'b0), .d(immIn), .q(immOut));
    pipeReg #(.T(word_t)) jumpFf (.clk, .rst, .clear(1'b0), .d(jumpDistIn), .q(jumpDistOut));

    pipeReg #(.T(funct_t)) functFf (.clk, .rst, .clear(1'b0), .d(functIn), .q(functOut));
    pipeReg #(.T(aluOp_t)) aluOpFf (.clk, .rst, .clear(1'b0), .d(aluOpIn), .q(aluOpOut));

    pipeReg #(.T(regIdx_t)) rsFf (.clk, .rst, .clear(1'b0), .d(rsIn), .q(rsOut));
    pipeReg #(.T(regIdx_t)) rtFf (.clk, .rst, .clear(1'b0), .d(rtIn), .q(rtOut));
    pipeReg #(.T(regIdx_t)) wrRegFf (.clk, .rst, .clear(1'b0), .d(writeRegIn),
        .q(writeRegOut));

    pipeReg #(.T(logic [4:0])) flagFf (
        .clk, .rst, .clear(1'b0),
        .d({aluSrcIn, branchNeIn, rsValidIn, rtValidIn, writeRegValidIn}),
        .q({aluSrcOut, branchNeOut, rsValidOut, rtValidOut, writeRegValidOut})
    );

    // A squashed entry turns into a NOP, so only the enables are cleared.
    pipeReg #(.T(logic [3:0])) enableFf (
        .clk, .rst, .clear(controlZeroIdEx),
        .d({regWriteIn, branchIn, jumpIn, haltIn}),
        .q({regWriteOut, branchOut, jumpOut, haltOut})
    );

    squashNoWrite: assert property (@(posedge clk) disable iff (rst)
        controlZeroIdEx |=> !regWriteOut);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regFile import isaPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regIdx_t rs,
    input  regIdx_t rt,
    output word_t   read1,
    output word_t   read2,
    input  logic    writeEn,
    input  regIdx_t writeReg,
    input  word_t   writeData
);

    localparam int NumRegs = 1 << $bits(regIdx_t);

    word_t regs [NumRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeReg] <= writeData;
        end
    end

    // Bypass so decode sees the value being written back this cycle.
    assign read1 = (writeEn && writeReg == rs) ? writeData : regs[rs];
    assign read2 = (writeEn && writeReg == rt) ? writeData : regs[rt];

    writeEnKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(writeEn));

endmodule

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder import isaPkg::*; (
    input  word_t   instr,
    output regIdx_t rs,
    output regIdx_t rt,
    output regIdx_t writeReg,
    output word_t   imm,
    output word_t   jumpDist,
    output aluOp_t  aluOp,
    output funct_t  funct,
    output logic    aluSrc,
    output logic    branch,
    output logic    branchNe,
    output logic    jump,
    output logic    regWrite,
    output logic    halt,
    output logic    rsValid,
    output logic    rtValid,
    output logic    writeRegValid
);

    opcode_t opcode;

    assign opcode   = opcode_t'(instr[OpcodeHi:OpcodeLo]);
    assign rs       = instr[RsHi:RsLo];
    assign rt       = instr[RtHi:RtLo];
    assign funct    = funct_t'(instr[FunctHi:FunctLo]);
    assign jumpDist = word_t'(signed'(instr[JumpWidth-1:0]));

    always_comb begin
        writeReg      = instr[IDestHi:IDestLo];
        imm           = '0;
        aluOp         = AluPass;
        aluSrc        = 1'b0;
        branch        = 1'b0;
        branchNe      = 1'b0;
        jump          = 1'b0;
        regWrite      = 1'b0;
        halt          = 1'b0;
        rsValid       = 1'b0;
        rtValid       = 1'b0;
        writeRegValid = 1'b0;
        case (opcode)
            OpRType: begin
                writeReg      = instr[RdHi:RdLo];
                aluOp         = AluFunct;
                regWrite      = 1'b1;
                rsValid       = 1'b1;
                rtValid       = 1'b1;
                writeRegValid = 1'b1;
            end
            OpAddi, OpXori: begin
                imm           = word_t'(signed'(instr[ImmWidth-1:0]));
                aluOp         = (opcode == OpAddi) ? AluAdd : AluXor;
                aluSrc        = 1'b1;
                regWrite      = 1'b1;
                rsValid       = 1'b1;
                writeRegValid = 1'b1;
            end
            OpBeqz, OpBnez: begin
                // Branches only test Rs against zero.
                imm      = word_t'(signed'(instr[BranchWidth-1:0]));
                branch   = 1'b1;
                branchNe = (opcode == OpBnez);
                rsValid  = 1'b1;
            end
            OpJ: begin
                jump = 1'b1;
            end
            OpHalt: begin
                halt = 1'b1;
            end
            default: begin
                // NOP, and any opcode not listed.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/pipeReg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  T     d,
    output T     q
);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            q <= T'(0);
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipePkg.sv ====
`default_nettype none

package pipePkg;

    typedef enum logic [1:0] {
        StateRun,
        StateDraining,
        StateHalted
    } ctrlState_t;

    localparam int CountWidth = 16;

endpackage

`default_nettype wire

// ==== source/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  regIdx_t;

    typedef enum logic [4:0] {
        OpNop   = 5'b00000,
        OpHalt  = 5'b00001,
        OpJ     = 5'b00100,
        OpAddi  = 5'b01000,
        OpXori  = 5'b01010,
        OpBeqz  = 5'b01100,
        OpBnez  = 5'b01101,
        OpRType = 5'b11011
    } opcode_t;

    // AluFunct defers the choice to the R-type funct field.
    typedef enum logic [4:0] {
        AluPass,
        AluAdd,
        AluSub,
        AluXor,
        AluAnd,
        AluFunct
    } aluOp_t;

    typedef enum logic [1:0] {
        FunctAdd = 2'b00,
        FunctSub = 2'b01,
        FunctXor = 2'b10,
        FunctAnd = 2'b11
    } funct_t;

    localparam int OpcodeHi = 15;
    localparam int OpcodeLo = 11;
    localparam int RsHi     = 10;
    localparam int RsLo     = 8;
    localparam int RtHi     = 7;
    localparam int RtLo     = 5;
    localparam int RdHi     = 4;
    localparam int RdLo     = 2;
    localparam int FunctHi  = 1;
    localparam int FunctLo  = 0;
    localparam int IDestHi  = 7;
    localparam int IDestLo  = 5;

    // Immediates start at bit 0.
    localparam int ImmWidth    = 5;
    localparam int BranchWidth = 8;
    localparam int JumpWidth   = 11;

    // Targets are PC + PcStep + offset.
    localparam word_t PcStep = 16'd2;

endpackage

`default_nettype wire
